//--- include/legv8_consts.svh
`ifndef LEGV8_CONSTS_SVH
`define LEGV8_CONSTS_SVH

// Register and data bus width.
`define DATA_WIDTH 64

// Architectural register count, X31 is XZR.
`define REG_COUNT 32

`define REG_IDX_WIDTH 5

// Destination of BL.
`define LINK_REG 30

`endif

//--- hw/legv8Pkg.sv
`include "legv8_consts.svh"

package legv8Pkg;

    // Match patterns on instr[31:21], ? bits are don't care.
    typedef enum logic [10:0] {
        opB    = 11'b000101?????,
        opBlt  = 11'b01010100???,
        opBl   = 11'b100101?????,
        opBr   = 11'b11010110000,
        opCbz  = 11'b10110100???,
        opAddi = 11'b10010001000,
        opAdds = 11'b10101011000,
        opSubs = 11'b11101011000,
        opLdur = 11'b11111000010,
        opStur = 11'b11111000000
    } opCode_t;

    typedef enum logic [2:0] {
        aluPassB = 3'b000,
        aluAdd   = 3'b010,
        aluSub   = 3'b011
    } aluOp_t;

    typedef enum logic [1:0] {
        brNone  = 2'b00,
        brPcRel = 2'b01,
        brReg   = 2'b10
    } brSel_t;

    typedef enum logic [1:0] {
        srcReg   = 2'b00,
        srcImm12 = 2'b01,
        srcImm9  = 2'b10
    } aluSrc_t;

    typedef enum logic [1:0] {
        wbAlu  = 2'b00,
        wbMem  = 2'b01,
        wbLink = 2'b10
    } wbSel_t;

    typedef struct packed {
        aluOp_t  aluOp;
        aluSrc_t aluSrc;
        wbSel_t  memToReg;
        brSel_t  brTaken;
        logic    reg2Loc;   // 1 reads Rm, 0 reads Rt.
        logic    reg2Write; // 1 writes the link register.
        logic    regWrite;
        logic    memWrite;
        logic    memRead;
        logic    uncondBr;  // 1 takes imm26, 0 takes imm19.
        logic    flagWrite;
    } ctrlSig_t;

    typedef struct packed {
        logic negative;
        logic zero;
        logic overflow;
        logic carry;
    } aluFlags_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`DATA_WIDTH-1:0] adr;
        logic [`DATA_WIDTH-1:0] datW;
    } wbReq_t;

    typedef struct packed {
        logic                   ack;
        logic [`DATA_WIDTH-1:0] datR;
    } wbRsp_t;

endpackage

//--- hw/controlSignal.sv
`timescale 1ns/1ps

module controlSignal
    import legv8Pkg::*;
(
    input  logic [31:0] instr,
    input  logic        aluZero,
    input  logic        bltTaken,
    output ctrlSig_t    ctrl
);

    always_comb begin
        // No-op values, kept for unknown opcodes.
        ctrl = '{
            aluOp:     aluPassB,
            aluSrc:    srcReg,
            memToReg:  wbAlu,
            brTaken:   brNone,
            reg2Loc:   1'b0,
            reg2Write: 1'b0,
            regWrite:  1'b0,
            memWrite:  1'b0,
            memRead:   1'b0,
            uncondBr:  1'b0,
            flagWrite: 1'b0
        };

        casez (instr[31:21])
            opB: begin
                ctrl.brTaken  = brPcRel;
                ctrl.uncondBr = 1'b1;
            end
            opBlt: begin
                ctrl.brTaken = bltTaken ? brPcRel : brNone; // N differs from V.
            end
            opBl: begin
                ctrl.brTaken   = brPcRel;
                ctrl.uncondBr  = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.reg2Write = 1'b1;
                ctrl.memToReg  = wbLink;
            end
            opBr: begin
                ctrl.brTaken = brReg; // Target comes from Rn.
            end
            opCbz: begin
                // Rt passes through the ALU so its zero flag decides.
                ctrl.aluOp   = aluPassB;
                ctrl.reg2Loc = 1'b0;
                ctrl.brTaken = aluZero ? brPcRel : brNone;
            end
            opAddi: begin
                ctrl.aluOp    = aluAdd;
                ctrl.aluSrc   = srcImm12;
                ctrl.regWrite = 1'b1;
            end
            opAdds: begin
                ctrl.aluOp     = aluAdd;
                ctrl.reg2Loc   = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.flagWrite = 1'b1;
            end
            opSubs: begin
                ctrl.aluOp     = aluSub;
                ctrl.reg2Loc   = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.flagWrite = 1'b1;
            end
            opLdur: begin
                ctrl.aluOp    = aluAdd;
                ctrl.aluSrc   = srcImm9;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = wbMem;
            end
            opStur: begin
                ctrl.aluOp    = aluAdd;
                ctrl.aluSrc   = srcImm9;
                ctrl.reg2Loc  = 1'b0;   // Store data is Rt.
                ctrl.memWrite = 1'b1;
            end
            default: begin
                ctrl.brTaken = brNone;
            end
        endcase
    end

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps
`include "legv8_consts.svh"

module regFile (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [`REG_IDX_WIDTH-1:0] rdIdxA,
    input  logic [`REG_IDX_WIDTH-1:0] rdIdxB,
    input  logic [`REG_IDX_WIDTH-1:0] wrIdx,
    input  logic                      wrEn,
    input  logic [`DATA_WIDTH-1:0]    wrData,
    output logic [`DATA_WIDTH-1:0]    rdDataA,
    output logic [`DATA_WIDTH-1:0]    rdDataB
);

    localparam logic [`REG_IDX_WIDTH-1:0] zeroIdx = `REG_IDX_WIDTH'(`REG_COUNT - 1);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrIdx != zeroIdx)) begin
            regs[wrIdx] <= wrData; // XZR writes are dropped.
        end
    end

    // XZR keeps its reset value since it is never written.
    assign rdDataA = regs[rdIdxA];
    assign rdDataB = regs[rdIdxB];

    // XZR must read as zero on both ports.
    assert property (@(posedge clk) disable iff (!rstN)
        ((rdIdxA == zeroIdx) -> (rdDataA == '0)) &&
        ((rdIdxB == zeroIdx) -> (rdDataB == '0)))
        else $error("XZR read returned a nonzero value");

endmodule

//--- hw/aluUnit.sv
`timescale 1ns/1ps
`include "legv8_consts.svh"

module aluUnit
    import legv8Pkg::*;
(
    input  logic [`DATA_WIDTH-1:0] opA,
    input  logic [`DATA_WIDTH-1:0] opB,
    input  aluOp_t                 aluOp,
    output logic [`DATA_WIDTH-1:0] result,
    output aluFlags_t              flags
);

    localparam int msb = `DATA_WIDTH - 1;

    logic [`DATA_WIDTH-1:0] opBEff;
    logic                   carryIn;
    logic [`DATA_WIDTH:0]   sum;

    // Subtract as A + ~B + 1.
    assign carryIn = (aluOp == aluSub);
    assign opBEff  = carryIn ? ~opB : opB;
    assign sum     = {1'b0, opA} + {1'b0, opBEff} + {{`DATA_WIDTH{1'b0}}, carryIn};

    always_comb begin
        case (aluOp)
            aluAdd, aluSub: begin
                result         = sum[msb:0];
                flags.carry    = sum[`DATA_WIDTH]; // Set means no borrow on subtract.
                // Same-sign operands giving an opposite-sign result.
                flags.overflow = (opA[msb] == opBEff[msb]) && (sum[msb] != opA[msb]);
            end
            default: begin
                result         = opB;
                flags.carry    = 1'b0;
                flags.overflow = 1'b0;
            end
        endcase
        flags.negative = result[msb];
        flags.zero     = (result == '0);
    end

endmodule

//--- hw/dataBusMaster.sv
`timescale 1ns/1ps
`include "legv8_consts.svh"

module dataBusMaster
    import legv8Pkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   start,
    input  logic                   write,
    input  logic [`DATA_WIDTH-1:0] addr,
    input  logic [`DATA_WIDTH-1:0] wrData,
    output wbReq_t                 wbReq,
    input  wbRsp_t                 wbRsp,
    output logic                   busy,
    output logic                   done,
    output logic [`DATA_WIDTH-1:0] rdData
);

    typedef enum logic [1:0] {
        stIdle,
        stActive,
        stFinish
    } busState_t;

    busState_t              state;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`DATA_WIDTH-1:0] adrQ;
    logic [`DATA_WIDTH-1:0] datWQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
            cyc   <= 1'b0;
            stb   <= 1'b0;
            we    <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (start) begin
                        state <= stActive;
                        cyc   <= 1'b1;
                        stb   <= 1'b1;
                        we    <= write;
                    end
                end
                stActive: begin
                    if (wbRsp.ack) begin
                        state <= stFinish;
                        cyc   <= 1'b0;
                        stb   <= 1'b0;
                        we    <= 1'b0;
                    end
                end
                stFinish: state <= stIdle; // One idle bus cycle between transfers.
                default:  state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == stIdle) && start) begin
            adrQ  <= addr;
            datWQ <= wrData;
        end
    end

    assign wbReq = '{cyc: cyc, stb: stb, we: we, adr: adrQ, datW: datWQ};

    // Busy covers the request cycle and every wait for ack.
    assign busy   = (state == stActive) ? !wbRsp.ack : start;
    assign done   = (state == stActive) && wbRsp.ack;
    assign rdData = wbRsp.datR;

    assert property (@(posedge clk) disable iff (!rstN) wbReq.stb |-> wbReq.cyc)
        else $error("Wishbone stb raised without cyc");

    // Request must hold until the slave acknowledges.
    assert property (@(posedge clk) disable iff (!rstN)
        (wbReq.cyc && wbReq.stb && !wbRsp.ack) |=>
            ($stable(wbReq.adr) && $stable(wbReq.we) && $stable(wbReq.datW)))
        else $error("Wishbone request changed before ack");

endmodule

//--- hw/legv8Cpu.sv
`timescale 1ns/1ps
`include "legv8_consts.svh"

module legv8Cpu
    import legv8Pkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    output logic [`DATA_WIDTH-1:0] instrAddr,
    input  logic [31:0]            instr,
    output wbReq_t                 wbReq,
    input  wbRsp_t                 wbRsp
);

    logic [`DATA_WIDTH-1:0]    pc;
    logic [`DATA_WIDTH-1:0]    pcPlus4;
    logic [`DATA_WIDTH-1:0]    brOffset;
    logic [`DATA_WIDTH-1:0]    nextPc;
    logic [`DATA_WIDTH-1:0]    imm12Ext;
    logic [`DATA_WIDTH-1:0]    imm9Ext;
    ctrlSig_t                  ctrl;
    aluFlags_t                 aluFlags;
    aluFlags_t                 flagReg;
    logic                      bltTaken;
    logic [`REG_IDX_WIDTH-1:0] rdIdxB;
    logic [`REG_IDX_WIDTH-1:0] wrIdx;
    logic                      regWrEn;
    logic [`DATA_WIDTH-1:0]    wrData;
    logic [`DATA_WIDTH-1:0]    rdDataA;
    logic [`DATA_WIDTH-1:0]    rdDataB;
    logic [`DATA_WIDTH-1:0]    aluOpB;
    logic [`DATA_WIDTH-1:0]    aluResult;
    logic                      memStart;
    logic                      busBusy;
    logic                      busDone;
    logic [`DATA_WIDTH-1:0]    busRdData;

    assign instrAddr = pc;
    assign pcPlus4   = pc + `DATA_WIDTH'(4);

    assign imm12Ext = {{(`DATA_WIDTH-12){1'b0}}, instr[21:10]};
    assign imm9Ext  = {{(`DATA_WIDTH-9){instr[20]}}, instr[20:12]};

    // Word offsets scaled to bytes.
    assign brOffset = ctrl.uncondBr ? {{(`DATA_WIDTH-28){instr[25]}}, instr[25:0], 2'b00}
                                    : {{(`DATA_WIDTH-21){instr[23]}}, instr[23:5], 2'b00};

    always_comb begin
        case (ctrl.brTaken)
            brPcRel: nextPc = pc + brOffset;
            brReg:   nextPc = rdDataA;
            default: nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!busBusy) begin
            pc <= nextPc; // Held while a bus cycle is outstanding.
        end
    end

    assign bltTaken = flagReg.negative ^ flagReg.overflow;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flagReg <= '0;
        end else if (ctrl.flagWrite) begin
            flagReg <= aluFlags;
        end
    end

    controlSignal controlSignal_i (
        .instr    (instr),
        .aluZero  (aluFlags.zero),
        .bltTaken (bltTaken),
        .ctrl     (ctrl)
    );

    assign rdIdxB = ctrl.reg2Loc ? instr[20:16] : instr[4:0];
    assign wrIdx  = ctrl.reg2Write ? `REG_IDX_WIDTH'(`LINK_REG) : instr[4:0];

    always_comb begin
        case (ctrl.memToReg)
            wbMem:   wrData = busRdData;
            wbLink:  wrData = pcPlus4;
            default: wrData = aluResult;
        endcase
    end

    // Loads write only on the acknowledged edge.
    assign regWrEn = ctrl.regWrite && (!memStart || busDone);

    regFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdIdxA  (instr[9:5]),
        .rdIdxB  (rdIdxB),
        .wrIdx   (wrIdx),
        .wrEn    (regWrEn),
        .wrData  (wrData),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    always_comb begin
        case (ctrl.aluSrc)
            srcImm12: aluOpB = imm12Ext;
            srcImm9:  aluOpB = imm9Ext;
            default:  aluOpB = rdDataB;
        endcase
    end

    aluUnit aluUnit_i (
        .opA    (rdDataA),
        .opB    (aluOpB),
        .aluOp  (ctrl.aluOp),
        .result (aluResult),
        .flags  (aluFlags)
    );

    assign memStart = ctrl.memRead || ctrl.memWrite;

    dataBusMaster dataBusMaster_i (
        .clk    (clk),
        .rstN   (rstN),
        .start  (memStart),
        .write  (ctrl.memWrite),
        .addr   (aluResult),
        .wrData (rdDataB),
        .wbReq  (wbReq),
        .wbRsp  (wbRsp),
        .busy   (busBusy),
        .done   (busDone),
        .rdData (busRdData)
    );

    assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("PC lost word alignment");

endmodule

//--- verif/legv8CpuTb.sv
`timescale 1ns/1ps
`include "legv8_consts.svh"

module legv8CpuTb
    import legv8Pkg::*;
();

    localparam logic [10:0] opAddsBits  = 11'b10101011000;
    localparam logic [10:0] opSubsBits  = 11'b11101011000;
    localparam logic [10:0] opLdurBits  = 11'b11111000010;
    localparam logic [10:0] opSturBits  = 11'b11111000000;
    localparam logic [5:0]  opBBits     = 6'b000101;
    localparam logic [5:0]  opBlBits    = 6'b100101;
    localparam logic [7:0]  opCbzBits   = 8'b10110100;
    localparam logic [7:0]  opBcondBits = 8'b01010100;
    localparam logic [31:0] nopWord     = 32'hD503201F; // Unknown to the core.
    localparam int          haltTimeout = 400;

    logic                   clk;
    logic                   rstN;
    logic [`DATA_WIDTH-1:0] instrAddr;
    logic [31:0]            instr;
    wbReq_t                 wbReq;
    wbRsp_t                 wbRsp;

    logic [31:0]            prog [64];
    int                     progLen;
    logic [`DATA_WIDTH-1:0] memData [256];
    wbReq_t                 storeQ[$];
    wbReq_t                 loadQ[$];
    wbReq_t                 expStoreQ[$];
    wbReq_t                 expLoadQ[$];
    logic [15:0]            lfsrState;
    logic                   slavePending;
    int                     ackWait;
    int                     checkCount;
    int                     errCount;
    int                     timeoutCount;

    legv8Cpu legv8Cpu_i (
        .clk       (clk),
        .rstN      (rstN),
        .instrAddr (instrAddr),
        .instr     (instr),
        .wbReq     (wbReq),
        .wbRsp     (wbRsp)
    );

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic drawBits(input int n, output logic [63:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[62:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    function automatic logic [63:0] fillWord(input logic [63:0] adr);
        return {adr[31:0] ^ 32'h5A5A_C3C3, ~adr[31:0]};
    endfunction

    function automatic logic [31:0] encAddi(input int rd, input int rn, input int imm);
        return {10'b1001000100, 12'(imm), 5'(rn), 5'(rd)};
    endfunction

    function automatic logic [31:0] encRType(input logic [10:0] op, input int rd,
                                             input int rn, input int rm);
        return {op, 5'(rm), 6'b000000, 5'(rn), 5'(rd)};
    endfunction

    function automatic logic [31:0] encDType(input logic [10:0] op, input int rt,
                                             input int rn, input int imm);
        return {op, 9'(imm), 2'b00, 5'(rn), 5'(rt)};
    endfunction

    function automatic logic [31:0] encB(input logic [5:0] op, input int words);
        return {op, 26'(words)};
    endfunction

    function automatic logic [31:0] encCb(input logic [7:0] op, input int rt, input int words);
        return {op, 19'(words), 5'(rt)};
    endfunction

    function automatic logic [31:0] encBr(input int rn);
        return {11'b11010110000, 5'b11111, 6'b000000, 5'(rn), 5'b00000};
    endfunction

    // Fetch ROM, refreshed on the falling edge after each PC change.
    always @(negedge clk) begin
        instr = (instrAddr < 64'd256) ? prog[instrAddr[7:2]] : nopWord;
    end

    // Wishbone slave with 0 to 3 wait cycles per request.
    always @(negedge clk) begin
        logic [63:0] bits;
        if (!rstN) begin
            wbRsp        = '0;
            slavePending = 1'b0;
            ackWait      = 0;
        end else if (wbRsp.ack) begin
            wbRsp.ack = 1'b0;
        end else if (wbReq.cyc && wbReq.stb) begin
            if (!slavePending) begin
                drawBits(2, bits);
                ackWait      = int'(bits[1:0]);
                slavePending = 1'b1;
            end
            if (ackWait == 0) begin
                if (wbReq.we) begin
                    memData[wbReq.adr[10:3]] = wbReq.datW;
                    storeQ.push_back(wbReq);
                end else begin
                    wbRsp.datR = memData[wbReq.adr[10:3]];
                    loadQ.push_back(wbReq);
                end
                wbRsp.ack    = 1'b1;
                slavePending = 1'b0;
            end else begin
                ackWait--;
            end
        end
    end

    task automatic checkStore(input wbReq_t got, input logic [63:0] expAdr,
                              input logic [63:0] expDat, input string what);
        checkCount++;
        if (!got.we || got.adr !== expAdr || got.datW !== expDat) begin
            errCount++;
            $display("FAILED @%0t: %s store to %h data %h, expected %h data %h",
                     $time, what, got.adr, got.datW, expAdr, expDat);
        end
    endtask

    task automatic checkLoadAddr(input wbReq_t got, input logic [63:0] expAdr,
                                 input string what);
        checkCount++;
        if (got.we || got.adr !== expAdr) begin
            errCount++;
            $display("FAILED @%0t: %s load from %h (we %b), expected %h",
                     $time, what, got.adr, got.we, expAdr);
        end
    endtask

    task automatic checkTransferCount(input int got, input int exp, input string what);
        checkCount++;
        if (got != exp) begin
            errCount++;
            $display("FAILED @%0t: %s saw %0d transfers, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic clearProgram();
        for (int i = 0; i < 64; i++) begin
            prog[i] = nopWord;
        end
        progLen = 0;
        expStoreQ.delete();
        expLoadQ.delete();
    endtask

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic expectStore(input logic [63:0] adr, input logic [63:0] dat);
        expStoreQ.push_back('{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, datW: dat});
    endtask

    task automatic expectLoad(input logic [63:0] adr);
        expLoadQ.push_back('{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, datW: '0});
    endtask

    task automatic resetDut();
        @(negedge clk);
        rstN = 1'b0;
        repeat (3) @(negedge clk);
        storeQ.delete();
        loadQ.delete();
        rstN = 1'b1;
    endtask

    // Last instruction of each program is a branch to itself.
    task automatic runProgram(input string name);
        logic [63:0] haltAddr;
        int          cycles;
        haltAddr = 64'((progLen - 1) * 4);
        resetDut();
        cycles = 0;
        while ((instrAddr !== haltAddr || storeQ.size() < expStoreQ.size())
               && cycles < haltTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= haltTimeout) begin
            timeoutCount++;
            $display("Timeout: program %s never reached its halt loop", name);
        end
        checkTransferCount(storeQ.size(), expStoreQ.size(), {name, " stores"});
        checkTransferCount(loadQ.size(), expLoadQ.size(), {name, " loads"});
        for (int i = 0; i < storeQ.size() && i < expStoreQ.size(); i++) begin
            checkStore(storeQ[i], expStoreQ[i].adr, expStoreQ[i].datW, name);
        end
        for (int i = 0; i < loadQ.size() && i < expLoadQ.size(); i++) begin
            checkLoadAddr(loadQ[i], expLoadQ[i].adr, name);
        end
    endtask

    task automatic testArith();
        logic [63:0] x3;
        logic [63:0] x4;
        x3 = 64'd100 - 64'd2000;
        x4 = x3 + 64'd100;
        clearProgram();
        emit(encAddi(1, 31, 100));
        emit(encAddi(2, 31, 2000));
        emit(encRType(opSubsBits, 3, 1, 2));
        emit(encRType(opAddsBits, 4, 3, 1));
        emit(encAddi(9, 31, 256));
        emit(encDType(opSturBits, 3, 9, 8));
        emit(encDType(opSturBits, 4, 9, -16));
        emit(encRType(opAddsBits, 5, 2, 2));
        emit(encDType(opSturBits, 5, 9, 0));
        emit(encB(opBBits, 0));
        expectStore(64'd264, x3);
        expectStore(64'd240, x4);
        expectStore(64'd256, 64'd4000);
        runProgram("arith");
    endtask

    task automatic testLoads();
        logic [63:0] v1;
        logic [63:0] v2;
        drawBits(64, v1);
        drawBits(64, v2);
        memData[64] = v1; // Address 512.
        memData[65] = v2;
        clearProgram();
        emit(encAddi(9, 31, 512));
        emit(encDType(opLdurBits, 1, 9, 0));
        emit(encDType(opLdurBits, 2, 9, 8));
        emit(encRType(opAddsBits, 3, 1, 2));
        emit(encDType(opSturBits, 3, 9, 16));
        emit(encDType(opLdurBits, 4, 9, 16));
        emit(encAddi(5, 4, 1));
        emit(encDType(opSturBits, 5, 9, 24));
        emit(encB(opBBits, 0));
        expectLoad(64'd512);
        expectLoad(64'd520);
        expectLoad(64'd528);
        expectStore(64'd528, v1 + v2);
        expectStore(64'd536, v1 + v2 + 64'd1);
        runProgram("loads");
    endtask

    task automatic testFlags();
        clearProgram();
        emit(encAddi(1, 31, 5));
        emit(encAddi(2, 31, 9));
        emit(encAddi(9, 31, 128));
        emit(encRType(opSubsBits, 3, 1, 2));  // Negative, so LT holds.
        emit(encAddi(4, 31, 7));
        emit(encCb(opBcondBits, 5'h0B, 2));
        emit(encDType(opSturBits, 4, 9, 0));  // Skipped.
        emit(encAddi(5, 31, 11));
        emit(encDType(opSturBits, 5, 9, 8));
        emit(encRType(opSubsBits, 3, 2, 1));  // Positive, falls through.
        emit(encAddi(6, 31, 13));
        emit(encCb(opBcondBits, 5'h0B, 2));
        emit(encDType(opSturBits, 6, 9, 16));
        emit(encDType(opSturBits, 3, 9, 24));
        emit(encB(opBBits, 0));
        expectStore(64'd136, 64'd11);
        expectStore(64'd144, 64'd13);
        expectStore(64'd152, 64'd4);
        runProgram("flags");
    endtask

    task automatic testCbzB();
        clearProgram();
        emit(encAddi(9, 31, 64));
        emit(encAddi(1, 31, 3));
        emit(encCb(opCbzBits, 2, 2));         // X2 is zero after reset.
        emit(encDType(opSturBits, 1, 9, 0));
        emit(encCb(opCbzBits, 1, 2));
        emit(encDType(opSturBits, 1, 9, 8));
        emit(encB(opBBits, 2));
        emit(encDType(opSturBits, 1, 9, 16)); // Never reached.
        emit(encAddi(3, 31, 21));
        emit(encDType(opSturBits, 3, 9, 24));
        emit(encB(opBBits, 0));
        expectStore(64'd72, 64'd3);
        expectStore(64'd88, 64'd21);
        runProgram("cbz");
    endtask

    task automatic testCall();
        clearProgram();
        emit(encAddi(9, 31, 320));
        emit(encB(opBlBits, 4));
        emit(encDType(opSturBits, 30, 9, 0));
        emit(encAddi(2, 31, 77));
        emit(encB(opBBits, 4));
        emit(encAddi(1, 31, 55));             // Subroutine.
        emit(encDType(opSturBits, 1, 9, 8));
        emit(encBr(30));
        emit(encDType(opSturBits, 2, 9, 16));
        emit(encB(opBBits, 0));
        expectStore(64'd328, 64'd55);
        expectStore(64'd320, 64'd4 + 64'd4); // BL sits at address 4.
        expectStore(64'd336, 64'd77);
        runProgram("call");
    endtask

    task automatic testZeroReg();
        clearProgram();
        emit(encAddi(9, 31, 400));
        emit(encAddi(31, 31, 99));
        emit(encDType(opSturBits, 31, 9, 0));
        emit(encAddi(1, 31, 42));
        emit(32'hD5032001);                   // Rd field points at X1.
        emit(32'h00000001);
        emit(encDType(opSturBits, 1, 9, 8));
        emit(encB(opBBits, 0));
        expectStore(64'd400, 64'd0);
        expectStore(64'd408, 64'd42);
        runProgram("xzr");
    endtask

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        instr        = nopWord;
        wbRsp        = '0;
        lfsrState    = 16'd38495;
        slavePending = 1'b0;
        ackWait      = 0;
        checkCount   = 0;
        errCount     = 0;
        timeoutCount = 0;
        progLen      = 0;
        for (int i = 0; i < 256; i++) begin
            memData[i] = fillWord(64'(i * 8));
        end

        testArith();
        testLoads();
        testFlags();
        testCbzB();
        testCall();
        testZeroReg();

        $display("Checks: %0d, value errors: %0d, timeouts: %0d",
                 checkCount, errCount, timeoutCount);
        if (errCount == 0 && timeoutCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- legv8Cpu.f
+incdir+include
hw/legv8Pkg.sv
hw/controlSignal.sv
hw/regFile.sv
hw/aluUnit.sv
hw/dataBusMaster.sv
hw/legv8Cpu.sv
verif/legv8CpuTb.sv
